/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = tb_icache_top
FILELIST  = src.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^NO ERRORS$$"

clean:
	rm -rf $(OBJ_DIR)

/* axi_boot_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_boot_rom #(
    parameter int rom_words = 1024
) (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic [3:0]  arid,
    input  logic [31:0] araddr,
    input  logic [3:0]  arlen,
    input  logic        arvalid,
    output logic        arready,
    output logic [3:0]  rid,
    output logic [31:0] rdata,
    output logic        rlast,
    output logic        rvalid,
    input  logic        rready
);

    localparam int ptr_bits   = $clog2(rom_words);
    localparam int step_words = (1 << icache_pkg::arsize_word) / 4;
    localparam bit incr_mode  = (icache_pkg::arburst_incr == 2'b01);

    logic [31:0]         mem [rom_words];
    logic [ptr_bits-1:0] word_ptr;
    logic [ptr_bits-1:0] start_ptr;
    logic [3:0]          beats_left;

    initial begin
        $readmemh("rom.hex", mem);
    end

    function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] p);
        logic [ptr_bits:0] sum;
        sum = {1'b0, p} + (ptr_bits+1)'(step_words);
        if (sum >= rom_words) begin
            sum = sum - (ptr_bits+1)'(rom_words);  // Wrap at the ROM end
        end
        return incr_mode ? sum[ptr_bits-1:0] : p;
    endfunction

    assign start_ptr = araddr[2 +: ptr_bits];  // Depth is a power of two

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            rlast      <= 1'b0;
            rid        <= '0;
            beats_left <= '0;
            word_ptr   <= '0;
        end else if (arvalid && arready) begin
            arready    <= 1'b0;
            rvalid     <= 1'b1;  // First beat next cycle
            rid        <= arid;
            beats_left <= arlen;
            rlast      <= (arlen == 4'd0);
            word_ptr   <= next_ptr(start_ptr);
        end else if (rvalid) begin
            if (rready) begin
                if (rlast) begin
                    rvalid <= 1'b0;
                    rlast  <= 1'b0;
                end else begin
                    beats_left <= beats_left - 1'b1;
                    rlast      <= (beats_left == 4'd1);
                    word_ptr   <= next_ptr(word_ptr);
                end
            end
        end else if (arvalid) begin
            arready <= 1'b1;  // One burst at a time
        end
    end

    always_ff @(posedge aclk) begin
        if (arvalid && arready) begin
            rdata <= mem[start_ptr];
        end else if (rvalid && rready && !rlast) begin
            rdata <= mem[word_ptr];
        end
    end

endmodule

`default_nettype wire

/* icache.sv */
`timescale 1ns/1ps
`default_nettype none

module icache #(
    parameter int index_bits = 5
) (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        bus_en,
    input  logic        bus_cached,
    input  logic        bus_stall,
    input  logic [31:0] bus_addr,
    output logic [31:0] bus_rdata,
    output logic        bus_streq,
    output logic [3:0]  arid,
    output logic [31:0] araddr,
    output logic [3:0]  arlen,
    output logic        arvalid,
    input  logic        arready,
    input  logic [3:0]  rid,
    input  logic [31:0] rdata,
    input  logic        rlast,
    input  logic        rvalid,
    output logic        rready
);

    localparam int addr_bits = index_bits + $clog2(icache_pkg::line_words);

    logic                 tag_hit;
    logic                 fill_start;
    logic [31:0]          fill_addr;
    logic                 fill_done;
    logic [3:0]           ram_wen;
    logic [addr_bits-1:0] ram_waddr;
    logic [31:0]          ram_wdata;
    logic [31:0]          ram_rdata;
    logic [31:0]          uc_word;
    logic [31:0]          uc_addr;
    logic                 uc_valid;
    logic                 uc_hit;
    logic                 served_cached;

    // Uncached buffer only serves its exact address
    assign uc_hit    = uc_valid && (uc_addr == bus_addr);
    assign bus_streq = bus_en && (bus_cached ? !tag_hit : !uc_hit);
    assign bus_rdata = served_cached ? ram_rdata : uc_word;

    icache_tag_store #(.index_bits(index_bits)) tag_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .lookup_addr (bus_addr),
        .hit         (tag_hit),
        .fill_start  (fill_start),
        .fill_addr   (fill_addr),
        .fill_done   (fill_done)
    );

    icache_data_ram #(.index_bits(index_bits)) ram_i (
        .aclk  (aclk),
        .wen   (ram_wen),
        .waddr (ram_waddr),
        .raddr (bus_addr[2 +: addr_bits]),  // Word address within the RAM
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    icache_refill #(.index_bits(index_bits)) refill_i (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .bus_en        (bus_en),
        .bus_cached    (bus_cached),
        .bus_addr      (bus_addr),
        .bus_stall     (bus_stall),
        .bus_streq     (bus_streq),
        .tag_hit       (tag_hit),
        .arid          (arid),
        .araddr        (araddr),
        .arlen         (arlen),
        .arvalid       (arvalid),
        .arready       (arready),
        .rid           (rid),
        .rdata         (rdata),
        .rlast         (rlast),
        .rvalid        (rvalid),
        .rready        (rready),
        .fill_start    (fill_start),
        .fill_addr     (fill_addr),
        .fill_done     (fill_done),
        .ram_wen       (ram_wen),
        .ram_waddr     (ram_waddr),
        .ram_wdata     (ram_wdata),
        .uc_word       (uc_word),
        .uc_addr       (uc_addr),
        .uc_valid      (uc_valid),
        .served_cached (served_cached)
    );

endmodule

`default_nettype wire

/* icache_data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_data_ram #(
    parameter int index_bits = 5
) (
    input  logic                                                    aclk,
    input  logic [3:0]                                              wen,
    input  logic [index_bits+$clog2(icache_pkg::line_words)-1:0] waddr,
    input  logic [index_bits+$clog2(icache_pkg::line_words)-1:0] raddr,
    input  logic [31:0]                                             wdata,
    output logic [31:0]                                             rdata
);

    localparam int addr_bits = index_bits + $clog2(icache_pkg::line_words);
    localparam int depth     = 1 << addr_bits;

    logic [31:0] mem [depth];

    always_ff @(posedge aclk) begin
        for (int b = 0; b < 4; b++) begin
            if (wen[b]) begin
                mem[waddr][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge aclk) begin
        rdata <= mem[raddr];  // Registered read port
    end

endmodule

`default_nettype wire

/* icache_pkg.sv */
`default_nettype none

package icache_pkg;

    // ############################
    // Line geometry
    // ############################
    localparam int line_words       = 16;
    localparam int line_offset_bits = 6;  // Byte offset in a 64-byte line

    // ############################
    // AXI read constants
    // ############################
    localparam logic [3:0] burst_len_cached   = 4'd15;  // 16 beats, one line
    localparam logic [3:0] burst_len_uncached = 4'd0;   // Single word
    localparam logic [2:0] arsize_word        = 3'b010;
    localparam logic [1:0] arburst_incr       = 2'b01;

    localparam logic [3:0] id_cached   = 4'd1;
    localparam logic [3:0] id_uncached = 4'd2;

    // ############################
    // Refill controller
    // ############################
    typedef enum logic [1:0] {
        st_idle,     // Waiting for a miss
        st_addr,     // Read address out
        st_data,     // Collecting beats
        st_release   // Waiting for the pipeline
    } refill_state_t;

endpackage

`default_nettype wire

/* icache_refill.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_refill #(
    parameter int index_bits = 5
) (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        bus_en,
    input  logic        bus_cached,
    input  logic [31:0] bus_addr,
    input  logic        bus_stall,
    input  logic        bus_streq,
    input  logic        tag_hit,
    output logic [3:0]  arid,
    output logic [31:0] araddr,
    output logic [3:0]  arlen,
    output logic        arvalid,
    input  logic        arready,
    input  logic [3:0]  rid,
    input  logic [31:0] rdata,
    input  logic        rlast,
    input  logic        rvalid,
    output logic        rready,
    output logic        fill_start,
    output logic [31:0] fill_addr,
    output logic        fill_done,
    output logic [3:0]  ram_wen,
    output logic [index_bits+$clog2(icache_pkg::line_words)-1:0] ram_waddr,
    output logic [31:0] ram_wdata,
    output logic [31:0] uc_word,
    output logic [31:0] uc_addr,
    output logic        uc_valid,
    output logic        served_cached
);

    localparam int word_sel_bits = $clog2(icache_pkg::line_words);
    localparam int off_bits      = icache_pkg::line_offset_bits;

    icache_pkg::refill_state_t state;

    logic [31:0]              req_addr;
    logic                     req_cached;
    logic [3:0]               req_id;
    logic [word_sel_bits-1:0] beat_cnt;
    logic                     beat;
    logic                     miss;

    assign miss   = (state == icache_pkg::st_idle) && bus_en && bus_streq;
    assign req_id = req_cached ? icache_pkg::id_cached : icache_pkg::id_uncached;
    assign beat   = (state == icache_pkg::st_data) && rvalid && (rid == req_id);

    // ############################
    // AXI read address and data
    // ############################
    assign arvalid = (state == icache_pkg::st_addr);
    assign arid    = req_id;
    assign araddr  = req_addr;
    assign arlen   = req_cached ? icache_pkg::burst_len_cached
                                : icache_pkg::burst_len_uncached;
    assign rready  = 1'b1;  // Never back-pressure

    // Tag update happens as the miss is taken
    assign fill_start = (state == icache_pkg::st_idle) && bus_en && bus_cached && !tag_hit;
    assign fill_addr  = (state == icache_pkg::st_idle) ? bus_addr : req_addr;
    assign fill_done  = beat && rlast && req_cached;

    assign ram_wen   = {4{beat && req_cached}};
    assign ram_waddr = {req_addr[off_bits +: index_bits], beat_cnt};
    assign ram_wdata = rdata;

    // ############################
    // Refill FSM
    // ############################
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state         <= icache_pkg::st_idle;
            req_cached    <= 1'b0;
            beat_cnt      <= '0;
            uc_valid      <= 1'b0;
            served_cached <= 1'b0;
        end else begin
            if (bus_en && !bus_streq) begin
                served_cached <= bus_cached;  // Steers next-cycle rdata
            end
            case (state)
                icache_pkg::st_idle: begin
                    if (miss) begin
                        req_cached <= bus_cached;
                        beat_cnt   <= '0;
                        state      <= icache_pkg::st_addr;
                    end
                end
                icache_pkg::st_addr: begin
                    if (arready) begin
                        state <= icache_pkg::st_data;
                    end
                end
                icache_pkg::st_data: begin
                    if (beat) begin
                        if (req_cached) begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end else if (rlast) begin
                            uc_valid <= 1'b1;
                        end
                        if (rlast) begin
                            state <= icache_pkg::st_release;
                        end
                    end
                end
                icache_pkg::st_release: begin
                    // Word taken, or the pipeline moved on
                    if (bus_stall == bus_streq) begin
                        state    <= icache_pkg::st_idle;
                        uc_valid <= 1'b0;
                    end
                end
                default: state <= icache_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (miss) begin
            req_addr <= bus_cached ? {bus_addr[31:off_bits], {off_bits{1'b0}}} : bus_addr;
        end
        if (beat && !req_cached) begin
            uc_word <= rdata;
            uc_addr <= req_addr;
        end
    end

endmodule

`default_nettype wire

/* icache_tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tag_store #(
    parameter int index_bits = 5
) (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic [31:0] lookup_addr,
    output logic        hit,
    input  logic        fill_start,
    input  logic [31:0] fill_addr,
    input  logic        fill_done
);

    localparam int lines    = 1 << index_bits;
    localparam int tag_lsb  = icache_pkg::line_offset_bits + index_bits;
    localparam int tag_bits = 32 - tag_lsb;

    logic [tag_bits-1:0]   tags [lines];
    logic [lines-1:0]      valid;

    logic [index_bits-1:0] lookup_idx;
    logic [tag_bits-1:0]   lookup_tag;
    logic [index_bits-1:0] fill_idx;
    logic [tag_bits-1:0]   fill_tag;

    assign lookup_idx = lookup_addr[icache_pkg::line_offset_bits +: index_bits];
    assign lookup_tag = lookup_addr[31:tag_lsb];
    assign fill_idx   = fill_addr[icache_pkg::line_offset_bits +: index_bits];
    assign fill_tag   = fill_addr[31:tag_lsb];

    assign hit = valid[lookup_idx] && (tags[lookup_idx] == lookup_tag);

    always_ff @(posedge aclk) begin
        if (fill_start) begin
            tags[fill_idx] <= fill_tag;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            valid <= '0;
        end else begin
            if (fill_start) begin
                valid[fill_idx] <= 1'b0;  // Line unusable until refilled
            end
            if (fill_done) begin
                valid[fill_idx] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
    parameter int index_bits = 5,
    parameter int rom_words  = 1024
) (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        bus_en,
    input  logic        bus_cached,
    input  logic        bus_stall,
    input  logic [31:0] bus_addr,
    output logic [31:0] bus_rdata,
    output logic        bus_streq
);

    // ############################
    // AXI read channel
    // ############################
    logic [3:0]  arid;
    logic [31:0] araddr;
    logic [3:0]  arlen;
    logic        arvalid;
    logic        arready;
    logic [3:0]  rid;
    logic [31:0] rdata;
    logic        rlast;
    logic        rvalid;
    logic        rready;

    icache #(.index_bits(index_bits)) icache_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .bus_en     (bus_en),
        .bus_cached (bus_cached),
        .bus_stall  (bus_stall),
        .bus_addr   (bus_addr),
        .bus_rdata  (bus_rdata),
        .bus_streq  (bus_streq),
        .arid       (arid),
        .araddr     (araddr),
        .arlen      (arlen),
        .arvalid    (arvalid),
        .arready    (arready),
        .rid        (rid),
        .rdata      (rdata),
        .rlast      (rlast),
        .rvalid     (rvalid),
        .rready     (rready)
    );

    axi_boot_rom #(.rom_words(rom_words)) rom_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arvalid (arvalid),
        .arready (arready),
        .rid     (rid),
        .rdata   (rdata),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready)
    );

endmodule

`default_nettype wire

/* rom.hex */
// Boot ROM image of 1024 hex words with 128 words per line
// Word n holds 5a000000 plus 4n
5a000000 5a000004 5a000008 5a00000c 5a000010 5a000014 5a000018 5a00001c 5a000020 5a000024 5a000028 5a00002c 5a000030 5a000034 5a000038 5a00003c 5a000040 5a000044 5a000048 5a00004c 5a000050 5a000054 5a000058 5a00005c 5a000060 5a000064 5a000068 5a00006c 5a000070 5a000074 5a000078 5a00007c 5a000080 5a000084 5a000088 5a00008c 5a000090 5a000094 5a000098 5a00009c 5a0000a0 5a0000a4 5a0000a8 5a0000ac 5a0000b0 5a0000b4 5a0000b8 5a0000bc 5a0000c0 5a0000c4 5a0000c8 5a0000cc 5a0000d0 5a0000d4 5a0000d8 5a0000dc 5a0000e0 5a0000e4 5a0000e8 5a0000ec 5a0000f0 5a0000f4 5a0000f8 5a0000fc 5a000100 5a000104 5a000108 5a00010c 5a000110 5a000114 5a000118 5a00011c 5a000120 5a000124 5a000128 5a00012c 5a000130 5a000134 5a000138 5a00013c 5a000140 5a000144 5a000148 5a00014c 5a000150 5a000154 5a000158 5a00015c 5a000160 5a000164 5a000168 5a00016c 5a000170 5a000174 5a000178 5a00017c 5a000180 5a000184 5a000188 5a00018c 5a000190 5a000194 5a000198 5a00019c 5a0001a0 5a0001a4 5a0001a8 5a0001ac 5a0001b0 5a0001b4 5a0001b8 5a0001bc 5a0001c0 5a0001c4 5a0001c8 5a0001cc 5a0001d0 5a0001d4 5a0001d8 5a0001dc 5a0001e0 5a0001e4 5a0001e8 5a0001ec 5a0001f0 5a0001f4 5a0001f8 5a0001fc
5a000200 5a000204 5a000208 5a00020c 5a000210 5a000214 5a000218 5a00021c 5a000220 5a000224 5a000228 5a00022c 5a000230 5a000234 5a000238 5a00023c 5a000240 5a000244 5a000248 5a00024c 5a000250 5a000254 5a000258 5a00025c 5a000260 5a000264 5a000268 5a00026c 5a000270 5a000274 5a000278 5a00027c 5a000280 5a000284 5a000288 5a00028c 5a000290 5a000294 5a000298 5a00029c 5a0002a0 5a0002a4 5a0002a8 5a0002ac 5a0002b0 5a0002b4 5a0002b8 5a0002bc 5a0002c0 5a0002c4 5a0002c8 5a0002cc 5a0002d0 5a0002d4 5a0002d8 5a0002dc 5a0002e0 5a0002e4 5a0002e8 5a0002ec 5a0002f0 5a0002f4 5a0002f8 5a0002fc 5a000300 5a000304 5a000308 5a00030c 5a000310 5a000314 5a000318 5a00031c 5a000320 5a000324 5a000328 5a00032c 5a000330 5a000334 5a000338 5a00033c 5a000340 5a000344 5a000348 5a00034c 5a000350 5a000354 5a000358 5a00035c 5a000360 5a000364 5a000368 5a00036c 5a000370 5a000374 5a000378 5a00037c 5a000380 5a000384 5a000388 5a00038c 5a000390 5a000394 5a000398 5a00039c 5a0003a0 5a0003a4 5a0003a8 5a0003ac 5a0003b0 5a0003b4 5a0003b8 5a0003bc 5a0003c0 5a0003c4 5a0003c8 5a0003cc 5a0003d0 5a0003d4 5a0003d8 5a0003dc 5a0003e0 5a0003e4 5a0003e8 5a0003ec 5a0003f0 5a0003f4 5a0003f8 5a0003fc
5a000400 5a000404 5a000408 5a00040c 5a000410 5a000414 5a000418 5a00041c 5a000420 5a000424 5a000428 5a00042c 5a000430 5a000434 5a000438 5a00043c 5a000440 5a000444 5a000448 5a00044c 5a000450 5a000454 5a000458 5a00045c 5a000460 5a000464 5a000468 5a00046c 5a000470 5a000474 5a000478 5a00047c 5a000480 5a000484 5a000488 5a00048c 5a000490 5a000494 5a000498 5a00049c 5a0004a0 5a0004a4 5a0004a8 5a0004ac 5a0004b0 5a0004b4 5a0004b8 5a0004bc 5a0004c0 5a0004c4 5a0004c8 5a0004cc 5a0004d0 5a0004d4 5a0004d8 5a0004dc 5a0004e0 5a0004e4 5a0004e8 5a0004ec 5a0004f0 5a0004f4 5a0004f8 5a0004fc 5a000500 5a000504 5a000508 5a00050c 5a000510 5a000514 5a000518 5a00051c 5a000520 5a000524 5a000528 5a00052c 5a000530 5a000534 5a000538 5a00053c 5a000540 5a000544 5a000548 5a00054c 5a000550 5a000554 5a000558 5a00055c 5a000560 5a000564 5a000568 5a00056c 5a000570 5a000574 5a000578 5a00057c 5a000580 5a000584 5a000588 5a00058c 5a000590 5a000594 5a000598 5a00059c 5a0005a0 5a0005a4 5a0005a8 5a0005ac 5a0005b0 5a0005b4 5a0005b8 5a0005bc 5a0005c0 5a0005c4 5a0005c8 5a0005cc 5a0005d0 5a0005d4 5a0005d8 5a0005dc 5a0005e0 5a0005e4 5a0005e8 5a0005ec 5a0005f0 5a0005f4 5a0005f8 5a0005fc
5a000600 5a000604 5a000608 5a00060c 5a000610 5a000614 5a000618 5a00061c 5a000620 5a000624 5a000628 5a00062c 5a000630 5a000634 5a000638 5a00063c 5a000640 5a000644 5a000648 5a00064c 5a000650 5a000654 5a000658 5a00065c 5a000660 5a000664 5a000668 5a00066c 5a000670 5a000674 5a000678 5a00067c 5a000680 5a000684 5a000688 5a00068c 5a000690 5a000694 5a000698 5a00069c 5a0006a0 5a0006a4 5a0006a8 5a0006ac 5a0006b0 5a0006b4 5a0006b8 5a0006bc 5a0006c0 5a0006c4 5a0006c8 5a0006cc 5a0006d0 5a0006d4 5a0006d8 5a0006dc 5a0006e0 5a0006e4 5a0006e8 5a0006ec 5a0006f0 5a0006f4 5a0006f8 5a0006fc 5a000700 5a000704 5a000708 5a00070c 5a000710 5a000714 5a000718 5a00071c 5a000720 5a000724 5a000728 5a00072c 5a000730 5a000734 5a000738 5a00073c 5a000740 5a000744 5a000748 5a00074c 5a000750 5a000754 5a000758 5a00075c 5a000760 5a000764 5a000768 5a00076c 5a000770 5a000774 5a000778 5a00077c 5a000780 5a000784 5a000788 5a00078c 5a000790 5a000794 5a000798 5a00079c 5a0007a0 5a0007a4 5a0007a8 5a0007ac 5a0007b0 5a0007b4 5a0007b8 5a0007bc 5a0007c0 5a0007c4 5a0007c8 5a0007cc 5a0007d0 5a0007d4 5a0007d8 5a0007dc 5a0007e0 5a0007e4 5a0007e8 5a0007ec 5a0007f0 5a0007f4 5a0007f8 5a0007fc
5a000800 5a000804 5a000808 5a00080c 5a000810 5a000814 5a000818 5a00081c 5a000820 5a000824 5a000828 5a00082c 5a000830 5a000834 5a000838 5a00083c 5a000840 5a000844 5a000848 5a00084c 5a000850 5a000854 5a000858 5a00085c 5a000860 5a000864 5a000868 5a00086c 5a000870 5a000874 5a000878 5a00087c 5a000880 5a000884 5a000888 5a00088c 5a000890 5a000894 5a000898 5a00089c 5a0008a0 5a0008a4 5a0008a8 5a0008ac 5a0008b0 5a0008b4 5a0008b8 5a0008bc 5a0008c0 5a0008c4 5a0008c8 5a0008cc 5a0008d0 5a0008d4 5a0008d8 5a0008dc 5a0008e0 5a0008e4 5a0008e8 5a0008ec 5a0008f0 5a0008f4 5a0008f8 5a0008fc 5a000900 5a000904 5a000908 5a00090c 5a000910 5a000914 5a000918 5a00091c 5a000920 5a000924 5a000928 5a00092c 5a000930 5a000934 5a000938 5a00093c 5a000940 5a000944 5a000948 5a00094c 5a000950 5a000954 5a000958 5a00095c 5a000960 5a000964 5a000968 5a00096c 5a000970 5a000974 5a000978 5a00097c 5a000980 5a000984 5a000988 5a00098c 5a000990 5a000994 5a000998 5a00099c 5a0009a0 5a0009a4 5a0009a8 5a0009ac 5a0009b0 5a0009b4 5a0009b8 5a0009bc 5a0009c0 5a0009c4 5a0009c8 5a0009cc 5a0009d0 5a0009d4 5a0009d8 5a0009dc 5a0009e0 5a0009e4 5a0009e8 5a0009ec 5a0009f0 5a0009f4 5a0009f8 5a0009fc
5a000a00 5a000a04 5a000a08 5a000a0c 5a000a10 5a000a14 5a000a18 5a000a1c 5a000a20 5a000a24 5a000a28 5a000a2c 5a000a30 5a000a34 5a000a38 5a000a3c 5a000a40 5a000a44 5a000a48 5a000a4c 5a000a50 5a000a54 5a000a58 5a000a5c 5a000a60 5a000a64 5a000a68 5a000a6c 5a000a70 5a000a74 5a000a78 5a000a7c 5a000a80 5a000a84 5a000a88 5a000a8c 5a000a90 5a000a94 5a000a98 5a000a9c 5a000aa0 5a000aa4 5a000aa8 5a000aac 5a000ab0 5a000ab4 5a000ab8 5a000abc 5a000ac0 5a000ac4 5a000ac8 5a000acc 5a000ad0 5a000ad4 5a000ad8 5a000adc 5a000ae0 5a000ae4 5a000ae8 5a000aec 5a000af0 5a000af4 5a000af8 5a000afc 5a000b00 5a000b04 5a000b08 5a000b0c 5a000b10 5a000b14 5a000b18 5a000b1c 5a000b20 5a000b24 5a000b28 5a000b2c 5a000b30 5a000b34 5a000b38 5a000b3c 5a000b40 5a000b44 5a000b48 5a000b4c 5a000b50 5a000b54 5a000b58 5a000b5c 5a000b60 5a000b64 5a000b68 5a000b6c 5a000b70 5a000b74 5a000b78 5a000b7c 5a000b80 5a000b84 5a000b88 5a000b8c 5a000b90 5a000b94 5a000b98 5a000b9c 5a000ba0 5a000ba4 5a000ba8 5a000bac 5a000bb0 5a000bb4 5a000bb8 5a000bbc 5a000bc0 5a000bc4 5a000bc8 5a000bcc 5a000bd0 5a000bd4 5a000bd8 5a000bdc 5a000be0 5a000be4 5a000be8 5a000bec 5a000bf0 5a000bf4 5a000bf8 5a000bfc
5a000c00 5a000c04 5a000c08 5a000c0c 5a000c10 5a000c14 5a000c18 5a000c1c 5a000c20 5a000c24 5a000c28 5a000c2c 5a000c30 5a000c34 5a000c38 5a000c3c 5a000c40 5a000c44 5a000c48 5a000c4c 5a000c50 5a000c54 5a000c58 5a000c5c 5a000c60 5a000c64 5a000c68 5a000c6c 5a000c70 5a000c74 5a000c78 5a000c7c 5a000c80 5a000c84 5a000c88 5a000c8c 5a000c90 5a000c94 5a000c98 5a000c9c 5a000ca0 5a000ca4 5a000ca8 5a000cac 5a000cb0 5a000cb4 5a000cb8 5a000cbc 5a000cc0 5a000cc4 5a000cc8 5a000ccc 5a000cd0 5a000cd4 5a000cd8 5a000cdc 5a000ce0 5a000ce4 5a000ce8 5a000cec 5a000cf0 5a000cf4 5a000cf8 5a000cfc 5a000d00 5a000d04 5a000d08 5a000d0c 5a000d10 5a000d14 5a000d18 5a000d1c 5a000d20 5a000d24 5a000d28 5a000d2c 5a000d30 5a000d34 5a000d38 5a000d3c 5a000d40 5a000d44 5a000d48 5a000d4c 5a000d50 5a000d54 5a000d58 5a000d5c 5a000d60 5a000d64 5a000d68 5a000d6c 5a000d70 5a000d74 5a000d78 5a000d7c 5a000d80 5a000d84 5a000d88 5a000d8c 5a000d90 5a000d94 5a000d98 5a000d9c 5a000da0 5a000da4 5a000da8 5a000dac 5a000db0 5a000db4 5a000db8 5a000dbc 5a000dc0 5a000dc4 5a000dc8 5a000dcc 5a000dd0 5a000dd4 5a000dd8 5a000ddc 5a000de0 5a000de4 5a000de8 5a000dec 5a000df0 5a000df4 5a000df8 5a000dfc
5a000e00 5a000e04 5a000e08 5a000e0c 5a000e10 5a000e14 5a000e18 5a000e1c 5a000e20 5a000e24 5a000e28 5a000e2c 5a000e30 5a000e34 5a000e38 5a000e3c 5a000e40 5a000e44 5a000e48 5a000e4c 5a000e50 5a000e54 5a000e58 5a000e5c 5a000e60 5a000e64 5a000e68 5a000e6c 5a000e70 5a000e74 5a000e78 5a000e7c 5a000e80 5a000e84 5a000e88 5a000e8c 5a000e90 5a000e94 5a000e98 5a000e9c 5a000ea0 5a000ea4 5a000ea8 5a000eac 5a000eb0 5a000eb4 5a000eb8 5a000ebc 5a000ec0 5a000ec4 5a000ec8 5a000ecc 5a000ed0 5a000ed4 5a000ed8 5a000edc 5a000ee0 5a000ee4 5a000ee8 5a000eec 5a000ef0 5a000ef4 5a000ef8 5a000efc 5a000f00 5a000f04 5a000f08 5a000f0c 5a000f10 5a000f14 5a000f18 5a000f1c 5a000f20 5a000f24 5a000f28 5a000f2c 5a000f30 5a000f34 5a000f38 5a000f3c 5a000f40 5a000f44 5a000f48 5a000f4c 5a000f50 5a000f54 5a000f58 5a000f5c 5a000f60 5a000f64 5a000f68 5a000f6c 5a000f70 5a000f74 5a000f78 5a000f7c 5a000f80 5a000f84 5a000f88 5a000f8c 5a000f90 5a000f94 5a000f98 5a000f9c 5a000fa0 5a000fa4 5a000fa8 5a000fac 5a000fb0 5a000fb4 5a000fb8 5a000fbc 5a000fc0 5a000fc4 5a000fc8 5a000fcc 5a000fd0 5a000fd4 5a000fd8 5a000fdc 5a000fe0 5a000fe4 5a000fe8 5a000fec 5a000ff0 5a000ff4 5a000ff8 5a000ffc

/* src.f */
icache_pkg.sv
icache_data_ram.sv
icache_tag_store.sv
icache_refill.sv
icache.sv
axi_boot_rom.sv
icache_top.sv
tb_icache_sva.sv
tb_icache_top.sv

/* tb_icache_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_bus_checks (
    input logic        aclk,
    input logic        aresetn,
    input logic        bus_en,
    input logic        bus_cached,
    input logic [31:0] bus_addr,
    input logic [31:0] bus_rdata,
    input logic        bus_streq,
    input logic        arvalid,
    input logic        arready,
    input logic        rvalid,
    input logic        rlast
);

    int unsigned fail_count = 0;

    // Expected boot ROM word with the index wrapped at 1024 words
    function automatic logic [31:0] rom_word(input logic [31:0] addr);
        return 32'h5a00_0000 + {20'h0, addr[11:2], 2'b00};
    endfunction

    // ############################
    // Fetch bus
    // ############################
    idle_quiet: assert property (@(posedge aclk) disable iff (!aresetn)
        !bus_en |-> !bus_streq)
        else begin
            fail_count++;
            $error("bus_streq high while bus_en is low");
        end

    served_data: assert property (@(posedge aclk) disable iff (!aresetn)
        (bus_en && !bus_streq) |=> (bus_rdata == rom_word($past(bus_addr))))
        else begin
            fail_count++;
            $error("bus_rdata differs from the boot ROM word");
        end

    uncached_goes_out: assert property (@(posedge aclk) disable iff (!aresetn)
        ($rose(bus_en) && !bus_cached) |-> bus_streq)
        else begin
            fail_count++;
            $error("uncached fetch served without a memory read");
        end

    // ############################
    // AXI read and reset
    // ############################
    reset_quiet: assert property (@(posedge aclk)
        !aresetn |=> (!arvalid && !rvalid))
        else begin
            fail_count++;
            $error("AXI valid high during or right after reset");
        end

    addr_held: assert property (@(posedge aclk) disable iff (!aresetn)
        (arvalid && !arready) |=> arvalid)
        else begin
            fail_count++;
            $error("arvalid dropped before arready");
        end

    burst_ends: assert property (@(posedge aclk) disable iff (!aresetn)
        (rvalid && rlast) |=> !rvalid)
        else begin
            fail_count++;
            $error("read data continued past rlast");
        end

endmodule

bind icache_top icache_bus_checks bus_checks_i (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .bus_en     (bus_en),
    .bus_cached (bus_cached),
    .bus_addr   (bus_addr),
    .bus_rdata  (bus_rdata),
    .bus_streq  (bus_streq),
    .arvalid    (arvalid),
    .arready    (arready),
    .rvalid     (rvalid),
    .rlast      (rlast)
);

`default_nettype wire

/* tb_icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_icache_top;

    localparam int index_bits   = 5;
    localparam int rom_words    = 1024;
    localparam int lines        = 1 << index_bits;
    localparam int offset_bits  = 6;  // 64-byte line
    localparam int tag_lsb      = offset_bits + index_bits;
    localparam int wait_limit   = 200;
    localparam int random_count = 300;

    logic        aclk;
    logic        aresetn;
    logic        bus_en;
    logic        bus_cached;
    logic        bus_stall;
    logic [31:0] bus_addr;
    logic [31:0] bus_rdata;
    logic        bus_streq;

    logic [31:0]        rom_model [rom_words];
    logic [31:tag_lsb]  model_tag [lines];
    logic [lines-1:0]   model_valid;

    icache_top #(.index_bits(index_bits), .rom_words(rom_words)) icache_top_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .bus_en     (bus_en),
        .bus_cached (bus_cached),
        .bus_stall  (bus_stall),
        .bus_addr   (bus_addr),
        .bus_rdata  (bus_rdata),
        .bus_streq  (bus_streq)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "Run stopped at the first error");
    endtask

    always @(negedge aclk) begin
        if (icache_top_i.bus_checks_i.fail_count != 0) begin
            abort_run("An assertion in the bound bus checker failed");
        end
    end

    // Direct-mapped lookup on the model tags
    function automatic logic predict_miss(input logic [31:0] addr, input logic cached);
        logic [index_bits-1:0] idx;
        idx = addr[offset_bits +: index_bits];
        if (!cached) begin
            return 1'b1;
        end
        return !(model_valid[idx] && (model_tag[idx] == addr[31:tag_lsb]));
    endfunction

    task automatic fetch(input logic [31:0] addr, input logic cached);
        int          waited;
        logic        exp_miss;
        logic [31:0] exp_word;
        exp_miss = predict_miss(addr, cached);
        exp_word = rom_model[(addr >> 2) % rom_words];
        @(posedge aclk);
        #1;
        bus_en     = 1'b1;
        bus_cached = cached;
        bus_addr   = addr;
        @(negedge aclk);
        if (bus_streq !== exp_miss) begin
            abort_run($sformatf("FAILED bus_streq addr=%08h got=%h exp=%h",
                                addr, bus_streq, exp_miss));
        end
        waited = 0;
        while (bus_streq) begin  // Refill in flight
            @(negedge aclk);
            waited++;
            if (waited > wait_limit) begin
                abort_run($sformatf("Timeout waiting for bus_streq to fall at address %08h",
                                    addr));
            end
        end
        @(posedge aclk);
        #1;
        bus_en = 1'b0;
        @(negedge aclk);
        if (bus_rdata !== exp_word) begin
            abort_run($sformatf("FAILED bus_rdata addr=%08h got=%08h exp=%08h",
                                addr, bus_rdata, exp_word));
        end
        if (cached) begin
            model_valid[addr[offset_bits +: index_bits]] = 1'b1;
            model_tag[addr[offset_bits +: index_bits]]   = addr[31:tag_lsb];
        end
    endtask

    initial begin
        logic [31:0] addr;
        logic        cached;
        void'($urandom(32'h89f5));
        $readmemh("rom.hex", rom_model);
        aresetn     = 1'b0;
        bus_en      = 1'b0;
        bus_cached  = 1'b0;
        bus_stall   = 1'b0;
        bus_addr    = '0;
        model_valid = '0;
        repeat (3) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        repeat (5) @(posedge aclk);  // Idle bus after reset

        fetch(32'h0000_0100, 1'b1);
        fetch(32'h0000_0040, 1'b1);
        fetch(32'h0000_007c, 1'b1);  // Same line hits
        fetch(32'h0000_0848, 1'b1);  // Same index with another tag
        fetch(32'h0000_0044, 1'b1);  // Evicted so misses again

        repeat (3) fetch(32'h0000_0200, 1'b0);
        fetch(32'h0000_0ffc, 1'b0);

        for (int n = 0; n < random_count; n++) begin
            addr   = 32'($urandom_range(rom_words - 1, 0)) << 2;
            cached = 1'($urandom_range(1, 0));
            fetch(addr, cached);
        end

        repeat (2) @(posedge aclk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire
